//--- Bender.yml
package:
  name: proc

export_include_dirs:
  - .

sources:
  - files:
      - proc_pkg.sv
      - proc_regfile.sv
      - proc_alu.sv
      - proc_control.sv
      - proc.sv
  - target: test
    files:
      - proc_props.sv
      - proc_tb.sv

//--- proc.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module proc (
    input  logic            Clock,
    input  logic            rstN,
    input  logic            run,
    input  proc_pkg::word_t din,
    output proc_pkg::word_t dout,
    output proc_pkg::word_t addr,
    output logic            w
);

    proc_pkg::ctrl_t   ctrl;
    proc_pkg::word_t   ir;
    proc_pkg::word_t   bus;
    proc_pkg::word_t   rfData;
    proc_pkg::word_t   g;
    proc_pkg::word_t   immSext;
    proc_pkg::word_t   immHigh;
    proc_pkg::regIdx_t rfReadIdx;
    proc_pkg::flags_t  flags;

    assign immSext   = {{(`PROC_WORD_W-`PROC_IMM_W){ir[`PROC_IMM_W-1]}}, ir[`PROC_IMM_W-1:0]};
    assign immHigh   = {ir[`PROC_WORD_W/2-1:0], {(`PROC_WORD_W/2){1'b0}}};   // mvt value
    assign rfReadIdx = ctrl.busSel[2:0];

    always_comb begin
        case (ctrl.busSel)
            proc_pkg::selG:       bus = g;
            proc_pkg::selImmSext: bus = immSext;
            proc_pkg::selImmHigh: bus = immHigh;
            proc_pkg::selDin:     bus = din;
            default:              bus = rfData;   // r0..pc
        endcase
    end

    always_ff @(posedge Clock) begin
        if (ctrl.irLoad) ir <= din;
    end

    // bus-side output registers
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            addr <= '0;
            dout <= '0;
            w    <= 1'b0;
        end else begin
            if (ctrl.addrLoad) addr <= bus;
            if (ctrl.doutLoad) dout <= bus;
            w <= ctrl.wrNext;   // one-cycle write strobe
        end
    end

    proc_control ctrlUnit (
        .Clock (Clock),
        .rstN  (rstN),
        .run   (run),
        .ir    (ir),
        .flags (flags),
        .ctrl  (ctrl)
    );

    proc_regfile regFile (
        .Clock     (Clock),
        .rstN      (rstN),
        .writeData (bus),
        .regWrite  (ctrl.regWrite),
        .regDst    (ctrl.regDst),
        .pcIncr    (ctrl.pcIncr),
        .readIdx   (rfReadIdx),
        .readData  (rfData)
    );

    proc_alu alu (
        .Clock     (Clock),
        .rstN      (rstN),
        .bOperand  (bus),
        .aLoad     (ctrl.aLoad),
        .gLoad     (ctrl.gLoad),
        .flagsLoad (ctrl.flagsLoad),
        .aluOp     (ctrl.aluOp),
        .g         (g),
        .flags     (flags)
    );

endmodule

//--- proc_alu.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module proc_alu (
    input  logic               Clock,
    input  logic               rstN,
    input  proc_pkg::word_t    bOperand,
    input  logic               aLoad,
    input  logic               gLoad,
    input  logic               flagsLoad,
    input  proc_pkg::aluOp_t   aluOp,
    output proc_pkg::word_t    g,
    output proc_pkg::flags_t   flags
);

    proc_pkg::word_t a;
    proc_pkg::word_t bInv;
    proc_pkg::word_t result;
    logic            carry;

    // kept at word width so the carry-out lands in the extra bit
    assign bInv = ~bOperand;

    always_comb begin
        carry  = 1'b0;
        result = '0;
        case (aluOp)
            proc_pkg::aluAdd: {carry, result} = a + bOperand;
            proc_pkg::aluSub: {carry, result} = a + bInv + 1'b1;
            proc_pkg::aluAnd: result = a & bOperand;   // carry stays clear
            default: ;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            a     <= '0;
            g     <= '0;
            flags <= '0;
        end else begin
            if (aLoad) a <= bOperand;   // A takes the bus
            if (gLoad) g <= result;
            if (flagsLoad) begin
                flags.c <= carry;
                flags.n <= result[`PROC_WORD_W-1];
                flags.z <= (result == '0);
            end
        end
    end

endmodule

//--- proc_control.sv
`timescale 1ns/1ps

module proc_control (
    input  logic              Clock,
    input  logic              rstN,
    input  logic              run,
    input  proc_pkg::word_t   ir,
    input  proc_pkg::flags_t  flags,
    output proc_pkg::ctrl_t   ctrl
);

    proc_pkg::opcode_t opcode;
    logic              immFlag;
    proc_pkg::regIdx_t rX;
    proc_pkg::regIdx_t rY;
    proc_pkg::cond_t   cond;
    logic              condHolds;
    logic              done;
    proc_pkg::tStep_t  state;
    proc_pkg::tStep_t  stateNext;

    function automatic proc_pkg::busSel_t toSel(proc_pkg::regIdx_t idx);
        return proc_pkg::busSel_t'({1'b0, idx});
    endfunction

    // word layout is III M XXX DDDDDDDDD, rY sits in the low bits
    assign opcode  = proc_pkg::opcode_t'(ir[15:13]);
    assign immFlag = ir[12];
    assign rX      = ir[11:9];
    assign rY      = ir[2:0];
    assign cond    = proc_pkg::cond_t'(ir[11:9]);

    always_comb begin
        case (cond)
            proc_pkg::condB:  condHolds = 1'b1;
            proc_pkg::condEq: condHolds = flags.z;
            proc_pkg::condNe: condHolds = !flags.z;
            proc_pkg::condCc: condHolds = !flags.c;
            proc_pkg::condCs: condHolds = flags.c;
            proc_pkg::condPl: condHolds = !flags.n;
            proc_pkg::condMi: condHolds = flags.n;
            default:          condHolds = 1'b0;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.busSel = proc_pkg::selG;
        ctrl.regDst = rX;
        ctrl.aluOp  = proc_pkg::aluAdd;
        done        = 1'b0;
        case (state)
            proc_pkg::tFetch: begin
                ctrl.busSel   = proc_pkg::selPc;   // pc out to ADDR
                ctrl.addrLoad = 1'b1;
                ctrl.pcIncr   = run;
            end
            proc_pkg::tWait: ;                      // memory turnaround
            proc_pkg::tLoadIr: ctrl.irLoad = 1'b1;
            proc_pkg::tExec1: begin
                case (opcode)
                    proc_pkg::opMv: begin
                        ctrl.busSel   = immFlag ? proc_pkg::selImmSext : toSel(rY);
                        ctrl.regWrite = 1'b1;
                        done          = 1'b1;
                    end
                    proc_pkg::opMvt: begin
                        if (immFlag) begin
                            ctrl.busSel   = proc_pkg::selImmHigh;
                            ctrl.regWrite = 1'b1;
                            done          = 1'b1;
                        end else if (cond == proc_pkg::condBl) begin
                            done = 1'b1;                    // no link register, no-op
                        end else begin
                            ctrl.busSel = proc_pkg::selPc;  // branch base into A
                            ctrl.aLoad  = 1'b1;
                        end
                    end
                    proc_pkg::opAdd, proc_pkg::opSub, proc_pkg::opAnd: begin
                        ctrl.busSel = toSel(rX);
                        ctrl.aLoad  = 1'b1;
                    end
                    proc_pkg::opLd, proc_pkg::opSt: begin
                        ctrl.busSel   = toSel(rY);          // address from rY
                        ctrl.addrLoad = 1'b1;
                    end
                    default: done = 1'b1;                   // opCs is a no-op
                endcase
            end
            proc_pkg::tExec2: begin
                case (opcode)
                    proc_pkg::opMvt: begin
                        ctrl.busSel = proc_pkg::selImmSext; // G = pc + offset
                        ctrl.gLoad  = 1'b1;
                    end
                    proc_pkg::opAdd, proc_pkg::opSub, proc_pkg::opAnd: begin
                        ctrl.busSel    = immFlag ? proc_pkg::selImmSext : toSel(rY);
                        ctrl.gLoad     = 1'b1;
                        ctrl.flagsLoad = 1'b1;
                        if (opcode == proc_pkg::opSub) begin
                            ctrl.aluOp = proc_pkg::aluSub;
                        end else if (opcode == proc_pkg::opAnd) begin
                            ctrl.aluOp = proc_pkg::aluAnd;
                        end
                    end
                    proc_pkg::opSt: begin
                        ctrl.busSel   = toSel(rX);
                        ctrl.doutLoad = 1'b1;
                        ctrl.wrNext   = 1'b1;
                        done          = 1'b1;
                    end
                    default: ;                              // ld waits for DIN
                endcase
            end
            proc_pkg::tExec3: begin
                done = 1'b1;
                case (opcode)
                    proc_pkg::opMvt: begin
                        ctrl.busSel   = proc_pkg::selG;
                        ctrl.regDst   = '1;                 // pc
                        ctrl.regWrite = condHolds;
                    end
                    proc_pkg::opAdd, proc_pkg::opSub, proc_pkg::opAnd: begin
                        ctrl.busSel   = proc_pkg::selG;
                        ctrl.regWrite = 1'b1;
                    end
                    proc_pkg::opLd: begin
                        ctrl.busSel   = proc_pkg::selDin;
                        ctrl.regWrite = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            proc_pkg::tFetch:  stateNext = run ? proc_pkg::tWait : proc_pkg::tFetch;
            proc_pkg::tWait:   stateNext = proc_pkg::tLoadIr;
            proc_pkg::tLoadIr: stateNext = proc_pkg::tExec1;
            proc_pkg::tExec1:  stateNext = done ? proc_pkg::tFetch : proc_pkg::tExec2;
            proc_pkg::tExec2:  stateNext = done ? proc_pkg::tFetch : proc_pkg::tExec3;
            default:           stateNext = proc_pkg::tFetch;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= proc_pkg::tFetch;
        end else begin
            state <= stateNext;
        end
    end

endmodule

//--- proc_defines.svh
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// data and address width of the core
`define PROC_WORD_W 16

// r0..r6 plus the pc
`define PROC_NUM_REGS 8

// immediate field of the instruction word
`define PROC_IMM_W 9

// word count of the memory model
`define PROC_MEM_DEPTH 256

`endif

//--- proc_pkg.sv
`include "proc_defines.svh"

package proc_pkg;

    typedef logic [`PROC_WORD_W-1:0] word_t;
    typedef logic [$clog2(`PROC_NUM_REGS)-1:0] regIdx_t;   // index 7 is the pc

    // instruction class in bits 15:13
    typedef enum logic [2:0] {
        opMv, opMvt, opAdd, opSub, opLd, opSt, opAnd, opCs
    } opcode_t;

    // branch condition, carried in the rX field
    typedef enum logic [2:0] {
        condB, condEq, condNe, condCc, condCs, condPl, condMi, condBl
    } cond_t;

    typedef enum logic [2:0] {
        tFetch, tWait, tLoadIr, tExec1, tExec2, tExec3
    } tStep_t;

    // bus sources, register values share their index
    typedef enum logic [3:0] {
        selR0, selR1, selR2, selR3, selR4, selR5, selR6, selPc,
        selG, selImmSext, selImmHigh, selDin
    } busSel_t;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd} aluOp_t;

    typedef struct packed {
        logic c;
        logic n;
        logic z;
    } flags_t;

    // one step's worth of datapath control
    typedef struct packed {
        busSel_t busSel;
        logic    regWrite;
        regIdx_t regDst;
        logic    pcIncr;
        logic    aLoad;
        logic    gLoad;
        logic    flagsLoad;
        logic    irLoad;
        logic    addrLoad;
        logic    doutLoad;
        aluOp_t  aluOp;
        logic    wrNext;   // W goes high next cycle
    } ctrl_t;

endpackage

//--- proc_props.sv
`timescale 1ns/1ps

module proc_props (
    input logic             Clock,
    input logic             rstN,
    input logic             w,
    input proc_pkg::word_t  addr,
    input proc_pkg::word_t  dout,
    input proc_pkg::tStep_t state
);

    // write strobe is a single-cycle pulse
    strobeSingle: assert property (@(posedge Clock) disable iff (!rstN) w |=> !w)
        else $error("w stayed high for two cycles");

    strobeInReset: assert property (@(posedge Clock) !rstN |=> !w)
        else $error("w high while in reset");

    // addr is set up before the strobe, dout holds until the memory takes it
    addrSetUp: assert property (@(posedge Clock) disable iff (!rstN) w |-> $stable(addr))
        else $error("addr changed as w went high");

    doutHeld: assert property (@(posedge Clock) disable iff (!rstN) w |=> $stable(dout))
        else $error("dout changed during the write cycle");

    stateLegal: assert property (@(posedge Clock) disable iff (!rstN)
        state inside {proc_pkg::tFetch, proc_pkg::tWait, proc_pkg::tLoadIr,
                      proc_pkg::tExec1, proc_pkg::tExec2, proc_pkg::tExec3})
        else $error("control state outside its encoding");

endmodule

bind proc proc_props props (
    .Clock (Clock),
    .rstN  (rstN),
    .w     (w),
    .addr  (addr),
    .dout  (dout),
    .state (ctrlUnit.state)
);

//--- proc_regfile.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module proc_regfile (
    input  logic              Clock,
    input  logic              rstN,
    input  proc_pkg::word_t   writeData,
    input  logic              regWrite,
    input  proc_pkg::regIdx_t regDst,
    input  logic              pcIncr,
    input  proc_pkg::regIdx_t readIdx,
    output proc_pkg::word_t   readData
);

    localparam int PcIdx = `PROC_NUM_REGS - 1;

    proc_pkg::word_t regs [`PROC_NUM_REGS];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < `PROC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `PROC_NUM_REGS; i++) begin
                if (regWrite && regDst == proc_pkg::regIdx_t'(i)) begin
                    regs[i] <= writeData;                 // a bus write beats the increment
                end else if (pcIncr && i == PcIdx) begin
                    regs[i] <= regs[i] + 1'b1;
                end
            end
        end
    end

    assign readData = regs[readIdx];   // combinational read port

endmodule

//--- proc_stimulus.txt
# P <addr> <word>   program word placed in the memory model
# E <addr> <data>   next expected store, data at 00F0 is a branch marker
P 00 11FD
P 01 325A
P 02 0400
P 03 1680
P 04 A003
P 05 5601
P 06 A203
P 07 5601
P 08 A403
P 09 1864
P 0A 1A1B
P 0B 4805
P 0C 5601
P 0D A803
P 0E 7810
P 0F D5F6
P 10 5601
P 11 A803
P 12 5601
P 13 A403
P 14 8C03
P 15 5601
P 16 AC03
P 17 10F0
P 18 6A05
P 19 1221
P 1A 2201
P 1B 1220
P 1C A200
P 1D 1231
P 1E 2401
P 1F 1230
P 20 A200
P 21 59F0
P 22 1241
P 23 2801
P 24 1240
P 25 A200
P 26 7860
P 27 1251
P 28 2C01
P 29 1250
P 2A A200
P 2B 21FF
E 0080 FFFD
E 0081 5A00
E 0082 FFFD
E 0083 007F
E 0084 006F
E 0085 FFF4
E 0086 FFF4
E 00F0 0021
E 00F0 0030
E 00F0 0041
E 00F0 0051

//--- proc_tb.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module proc_tb;

    localparam int              ResetCycles  = 5;
    localparam int              StoreTimeout = 60;    // cycles allowed between two stores
    localparam int              IdleCycles   = 30;
    localparam int              MemIdxW      = $clog2(`PROC_MEM_DEPTH);
    localparam proc_pkg::word_t MarkerAddr   = 16'h00F0;   // branch outcome mailbox

    logic            Clock;
    logic            rstN;
    logic            run;
    proc_pkg::word_t din;
    proc_pkg::word_t dout;
    proc_pkg::word_t addr;
    logic            w;

    proc_pkg::word_t mem [`PROC_MEM_DEPTH];
    proc_pkg::word_t memQ;
    proc_pkg::word_t expAddr [$];
    proc_pkg::word_t expData [$];
    int              errors;

    proc dut (
        .Clock (Clock),
        .rstN  (rstN),
        .run   (run),
        .din   (din),
        .dout  (dout),
        .addr  (addr),
        .w     (w)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    // synchronous memory with read data one clock after addr
    always @(posedge Clock) begin
        if (w) mem[addr[MemIdxW-1:0]] <= dout;
        memQ <= mem[addr[MemIdxW-1:0]];
    end

    always @(negedge Clock) din <= memQ;

    task automatic loadStimulus();
        int               fd;
        logic [8*8-1:0]   tag;
        logic [8*128-1:0] rest;
        proc_pkg::word_t  a;
        proc_pkg::word_t  d;
        for (int i = 0; i < `PROC_MEM_DEPTH; i++) begin
            mem[i] = 16'hE000 | proc_pkg::word_t'(i);   // unused words decode as no-ops
        end
        fd = $fopen("proc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open proc_stimulus.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                void'($fgets(rest, fd));
            end else if (tag == "P" && $fscanf(fd, "%h %h", a, d) == 2) begin
                mem[a[MemIdxW-1:0]] = d;
            end else if (tag == "E" && $fscanf(fd, "%h %h", a, d) == 2) begin
                expAddr.push_back(a);
                expData.push_back(d);
            end else begin
                $display("unreadable entry in proc_stimulus.txt, tag %0s", tag);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic checkStore(proc_pkg::word_t gotAddr, proc_pkg::word_t gotData);
        proc_pkg::word_t wantAddr;
        proc_pkg::word_t wantData;
        wantAddr = expAddr.pop_front();
        wantData = expData.pop_front();
        if (gotAddr !== wantAddr || gotData !== wantData) begin
            $display("[FAIL] %t store of %h to %h, expected %h to %h",
                     $time, gotData, gotAddr, wantData, wantAddr);
            errors++;
        end
    endtask

    // the marker value tells which way the branch went
    task automatic checkFlagsVisible(proc_pkg::word_t gotData);
        proc_pkg::word_t wantData;
        wantData = expData.pop_front();
        void'(expAddr.pop_front());
        if (gotData !== wantData) begin
            $display("[FAIL] %t branch marker %h, expected %h", $time, gotData, wantData);
            errors++;
        end
    endtask

    task automatic waitForStore(int idx, output logic seen);
        seen = 1'b0;
        for (int c = 0; c < StoreTimeout && !seen; c++) begin
            @(negedge Clock);
            seen = w;
        end
        if (!seen) begin
            $display("store %0d to address %h never arrived within %0d cycles",
                     idx, expAddr[0], StoreTimeout);
            errors++;
        end
    endtask

    // drop run and expect the core to stay parked in fetch
    task automatic holdRun(int cycles);
        proc_pkg::word_t heldAddr;
        run = 1'b0;
        @(negedge Clock);
        heldAddr = addr;
        for (int c = 0; c <= cycles; c++) begin
            if (w) begin
                $display("a store happened while run was low");
                errors++;
            end
            if (addr !== heldAddr) begin
                $display("[FAIL] %t addr moved to %h with run low, held %h",
                         $time, addr, heldAddr);
                errors++;
            end
            if (c < cycles) @(negedge Clock);
        end
        run = 1'b1;
    endtask

    initial begin
        int   total;
        int   checked;
        logic seen;
        logic lost;
        rstN    = 1'b0;
        run     = 1'b0;
        din     = '0;
        errors  = 0;
        checked = 0;
        lost    = 1'b0;
        seen    = 1'b0;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'hd936_f677));
        loadStimulus();
        total = expAddr.size();
        if (total == 0) begin
            $display("proc_stimulus.txt holds no expected stores");
            errors++;
        end

        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        holdRun(3);                            // parked right after reset
        if (addr !== '0) begin
            $display("[FAIL] %t first fetch address %h, expected 0000", $time, addr);
            errors++;
        end

        for (int i = 0; i < total && !lost; i++) begin
            waitForStore(i, seen);
            if (!seen) begin
                lost = 1'b1;
            end else begin
                if (addr === MarkerAddr && expAddr[0] === MarkerAddr) begin
                    checkFlagsVisible(dout);
                end else begin
                    checkStore(addr, dout);
                end
                checked++;
                if ($urandom % 3 == 0) holdRun(1 + $urandom % 4);   // short random gap
            end
        end

        // program ends in a branch to itself so nothing more may be written
        for (int c = 0; c < IdleCycles && !lost; c++) begin
            @(negedge Clock);
            if (w) begin
                $display("unexpected store of %h to %h after the last expected one", dout, addr);
                errors++;
            end
        end

        $display("stores checked: %0d of %0d, errors: %0d", checked, total, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
proc_pkg.sv
proc_regfile.sv
proc_alu.sv
proc_control.sv
proc.sv
proc_props.sv
proc_tb.sv
